// ==== design/fetch_defs.svh ====
// ----------------------------
// widths and sizes of the fetch stage
// FETCH_CNT_BITS must hold FETCH_MAX_INFLIGHT itself
// FETCH_MAX_INFLIGHT must be a power of two
// ----------------------------

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// byte address and instruction word
`define FETCH_ADDR_BITS 32
`define FETCH_INST_BITS 32

// memory opaque field, carries the fetch epoch
`define FETCH_OPAQ_BITS 8

// first pc fetched after reset
`define FETCH_RST_ADDR 32'h0000_1000

// requests issued but not yet handed to decode, also the buffer depth
`define FETCH_MAX_INFLIGHT 4
`define FETCH_CNT_BITS 3

`endif

// ==== design/fetch_pkg.sv ====
// ----------------------------
// types shared by the fetch stage
// message layouts follow the memory and decode ports
// ----------------------------

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // ----------------------------
  // plain vectors
  // ----------------------------
  typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;
  typedef logic [`FETCH_INST_BITS-1:0] inst_t;
  typedef logic [`FETCH_OPAQ_BITS-1:0] epoch_t;

  // ----------------------------
  // port messages
  // ----------------------------

  // fetch to memory, opaq carries the epoch
  typedef struct packed {
    addr_t  addr;
    epoch_t opaq;
  } mem_req_t;

  // memory to fetch, addr and opaq echoed back
  typedef struct packed {
    addr_t  addr;
    epoch_t opaq;
    inst_t  data;
  } mem_resp_t;

  // fetch to decode
  typedef struct packed {
    inst_t inst;
    addr_t pc;
  } f2d_msg_t;

  // decode to fetch, low two bits of target are ignored
  typedef struct packed {
    addr_t target;
  } redirect_t;

  // issue control states
  typedef enum logic [1:0] {
    IDLE_RESET,
    RUN,
    FULL
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== design/fetch_pc_gen.sv ====
// ----------------------------
// fetch pc register
// steps by 4 per request transfer
// redirect wins over the step
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc_gen
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // memory request handshake done this cycle
  input  logic      req_fire,
  // redirect strobe and target from decode
  input  logic      redirect_val,
  input  redirect_t redirect,
  // address of the next request
  output addr_t     pc
);

  // ----------------------------
  // next pc
  // ----------------------------

  // target word aligned, low two bits dropped
  addr_t target_aligned;
  // sequential successor
  addr_t pc_incr;

  assign target_aligned = {redirect.target[`FETCH_ADDR_BITS-1:2], 2'b00};
  assign pc_incr        = pc + addr_t'(4);

  // ----------------------------
  // pc register
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `FETCH_RST_ADDR;
    end else if (redirect_val) begin
      // a request firing in the same cycle used the old pc
      // its response is killed by epoch later
      pc <= target_aligned;
    end else if (req_fire) begin
      pc <= pc_incr;
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
// ----------------------------
// issue control and stale response filter
// assumes memory answers every request in order
// a redirect while a request waits on rdy changes that request
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  // memory request side
  input  logic   mem_req_rdy,
  output logic   mem_req_val,
  output logic   req_fire,
  // memory response side
  input  logic   mem_resp_val,
  input  epoch_t resp_opaq,
  // decode side
  input  logic   pop_fire,
  input  logic   redirect_val,
  // current epoch, goes out in mem_req.opaq
  output epoch_t epoch,
  // accepted response goes to the buffer
  output logic   push
);

  localparam logic [`FETCH_CNT_BITS-1:0] MAX_CNT = `FETCH_CNT_BITS'(`FETCH_MAX_INFLIGHT);
  localparam logic [`FETCH_CNT_BITS-1:0] CNT_ONE = `FETCH_CNT_BITS'(1);

  fetch_state_t state;
  fetch_state_t state_next;

  // issued, not yet delivered, killed or flushed
  logic [`FETCH_CNT_BITS-1:0] credits;
  logic [`FETCH_CNT_BITS-1:0] credits_next;
  // issued, response not yet back
  logic [`FETCH_CNT_BITS-1:0] inflight;
  logic [`FETCH_CNT_BITS-1:0] inflight_next;
  // stale response, dropped here
  logic kill;

  // ----------------------------
  // handshakes and filter
  // ----------------------------

  // only RUN issues, it means credits below max
  assign mem_req_val = (state == RUN);
  assign req_fire    = mem_req_val & mem_req_rdy;

  // old epoch means a redirect came after the request went out
  assign push = mem_resp_val & (resp_opaq == epoch);
  assign kill = mem_resp_val & (resp_opaq != epoch);

  // ----------------------------
  // counters
  // ----------------------------

  always_comb begin
    inflight_next = inflight;
    if (req_fire) begin
      inflight_next = inflight_next + CNT_ONE;
    end
    // every response leaves flight, pushed or killed
    if (mem_resp_val) begin
      inflight_next = inflight_next - CNT_ONE;
    end
  end

  always_comb begin
    credits_next = credits;
    if (redirect_val) begin
      // buffer is flushed, only what is still in flight holds a credit
      credits_next = inflight_next;
    end else begin
      if (req_fire) begin
        credits_next = credits_next + CNT_ONE;
      end
      if (pop_fire) begin
        credits_next = credits_next - CNT_ONE;
      end
      if (kill) begin
        credits_next = credits_next - CNT_ONE;
      end
    end
  end

  // ----------------------------
  // state machine
  // ----------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE_RESET: state_next = RUN;
      RUN:        if (credits_next == MAX_CNT) state_next = FULL;
      FULL:       if (credits_next != MAX_CNT) state_next = RUN;
      default:    state_next = IDLE_RESET;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE_RESET;
      credits  <= '0;
      inflight <= '0;
      epoch    <= '0;
    end else begin
      state    <= state_next;
      credits  <= credits_next;
      inflight <= inflight_next;
      // new epoch after a redirect, older responses become stale
      if (redirect_val) begin
        epoch <= epoch + epoch_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_resp_buf.sv ====
// ----------------------------
// response FIFO toward decode
// no overflow check, credits in fetch_ctrl keep space
// flush drops all entries and any push in the same cycle
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_resp_buf
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // write side
  input  logic     push,
  input  f2d_msg_t push_msg,
  input  logic     flush,
  // decode side
  input  logic     d_rdy,
  output logic     d_val,
  output f2d_msg_t d_msg,
  output logic     pop_fire
);

  localparam int PTR_BITS = $clog2(`FETCH_MAX_INFLIGHT);
  localparam logic [`FETCH_CNT_BITS-1:0] CNT_ONE = `FETCH_CNT_BITS'(1);
  localparam logic [PTR_BITS-1:0] PTR_ONE = PTR_BITS'(1);

  // payload storage
  f2d_msg_t entries [`FETCH_MAX_INFLIGHT];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [`FETCH_CNT_BITS-1:0] count;

  // ----------------------------
  // decode port
  // ----------------------------

  // head entry is shown as soon as it is written
  assign d_val    = (count != '0);
  assign d_msg    = entries[rd_ptr];
  assign pop_fire = d_val & d_rdy;

  // ----------------------------
  // storage
  // ----------------------------

  // pointers wrap, depth is a power of two
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      entries[wr_ptr] <= push_msg;
    end
  end

  // ----------------------------
  // pointers and count
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // a pop this cycle still counts as delivered
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_ONE;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + PTR_ONE;
      end
      // push and pop together leave count as is
      if (push && !pop_fire) begin
        count <= count + CNT_ONE;
      end else if (pop_fire && !push) begin
        count <= count - CNT_ONE;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
// ----------------------------
// instruction fetch stage top
// memory must answer in order and echo addr and opaq
// responses are always accepted
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // memory request
  output logic      mem_req_val,
  input  logic      mem_req_rdy,
  output mem_req_t  mem_req,
  // memory response
  input  logic      mem_resp_val,
  input  mem_resp_t mem_resp,
  // decode port
  output logic      d_val,
  input  logic      d_rdy,
  output f2d_msg_t  d_msg,
  // redirect strobe from decode
  input  logic      redirect_val,
  input  redirect_t redirect
);

  logic     req_fire;
  logic     push;
  logic     pop_fire;
  addr_t    pc;
  epoch_t   epoch;
  f2d_msg_t push_msg;

  // ----------------------------
  // message forming
  // ----------------------------

  // request tagged with the current epoch
  assign mem_req.addr = pc;
  assign mem_req.opaq = epoch;

  // echoed addr is the instruction's pc
  assign push_msg.inst = mem_resp.data;
  assign push_msg.pc   = mem_resp.addr;

  // ----------------------------
  // submodules
  // ----------------------------

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_val  (mem_req_val),
    .req_fire     (req_fire),
    .mem_resp_val (mem_resp_val),
    .resp_opaq    (mem_resp.opaq),
    .pop_fire     (pop_fire),
    .redirect_val (redirect_val),
    .epoch        (epoch),
    .push         (push)
  );

  fetch_pc_gen u_pc_gen (
    .clk          (clk),
    .reset        (reset),
    .req_fire     (req_fire),
    .redirect_val (redirect_val),
    .redirect     (redirect),
    .pc           (pc)
  );

  // flush is the redirect strobe itself
  fetch_resp_buf u_resp_buf (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .push_msg (push_msg),
    .flush    (redirect_val),
    .d_rdy    (d_rdy),
    .d_val    (d_val),
    .d_msg    (d_msg),
    .pop_fire (pop_fire)
  );

endmodule

`default_nettype wire

// ==== test/fetch_unit_props.sv ====
// ------------------------------
// handshake and credit rules
// bound into every fetch_unit
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_props
  import fetch_pkg::*;
(
  input logic                       clk,
  input logic                       reset,
  input logic                       mem_req_val,
  input logic                       mem_req_rdy,
  input mem_req_t                   mem_req,
  input logic                       d_val,
  input logic                       d_rdy,
  input f2d_msg_t                   d_msg,
  input logic                       redirect_val,
  input logic [`FETCH_CNT_BITS-1:0] credits
);

  // failures seen so far
  int unsigned fail_count = 0;

  // nothing valid while reset is held
  a_quiet_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> !mem_req_val && !d_val)
    else begin
      fail_count = fail_count + 1;
      $error("valid high during reset");
    end

  // a redirect may change a waiting request
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy && !redirect_val |=> mem_req_val && $stable(mem_req))
    else begin
      fail_count = fail_count + 1;
      $error("memory request changed while stalled");
    end

  // flush on redirect empties the buffer
  a_dec_stable: assert property (@(posedge clk) disable iff (reset)
    d_val && !d_rdy && !redirect_val |=> d_val && $stable(d_msg))
    else begin
      fail_count = fail_count + 1;
      $error("decode message changed while stalled");
    end

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
    credits <= `FETCH_CNT_BITS'(`FETCH_MAX_INFLIGHT))
    else begin
      fail_count = fail_count + 1;
      $error("credit count above limit");
    end

endmodule

bind fetch_unit fetch_unit_props u_props (
  .clk          (clk),
  .reset        (reset),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_req      (mem_req),
  .d_val        (d_val),
  .d_rdy        (d_rdy),
  .d_msg        (d_msg),
  .redirect_val (redirect_val),
  .credits      (u_ctrl.credits)
);

`default_nettype wire

// ==== test/fetch_unit_tb.sv ====
// ------------------------------
// testbench for the fetch stage
// memory answers in order, 0 to 5 idle cycles late
// redirects start after the first 200 instructions
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_tb
  import fetch_pkg::*;
();

  localparam int NUM_INST       = 400;
  localparam int TIMEOUT_CYCLES = NUM_INST * 12;
  localparam int RESET_CYCLES   = 5;

  logic      clk;
  logic      reset;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_req_t  mem_req;
  logic      mem_resp_val;
  mem_resp_t mem_resp;
  logic      d_val;
  logic      d_rdy;
  f2d_msg_t  d_msg;
  logic      redirect_val;
  redirect_t redirect;

  logic [31:0] lcg_state;
  // requests waiting for their response, oldest first
  addr_t  pend_addr [$];
  epoch_t pend_opaq [$];
  int     pend_due [$];
  int     cycle;
  int     timeout_count;
  int     delivered;
  addr_t  exp_pc;
  logic   first_req_seen;
  logic   prev_redirect;
  int     stall_redirects;
  int     back_to_back;

  fetch_unit u_dut (
    .clk          (clk),
    .reset        (reset),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .d_val        (d_val),
    .d_rdy        (d_rdy),
    .d_msg        (d_msg),
    .redirect_val (redirect_val),
    .redirect     (redirect)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only, low LCG bits repeat quickly
  function automatic int unsigned random_below(input int unsigned limit);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 16) % limit;
  endfunction

  // instruction word stored at a byte address
  function automatic inst_t mem_data(input addr_t addr);
    inst_t mixed;
    mixed = addr * 32'h9E37_79B1;
    mixed = mixed ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    return mixed;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, actual, expected);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  // ------------------------------
  // memory, reference model, stimulus
  // ------------------------------

  always @(posedge clk) begin
    int unsigned delay;
    if (reset) begin
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
      d_rdy        <= 1'b0;
      redirect_val <= 1'b0;
    end else begin
      cycle = cycle + 1;
      // request transfer, first one must be the reset address
      if (mem_req_val && mem_req_rdy) begin
        if (!first_req_seen) begin
          compare_value("mem_req.addr", mem_req.addr, `FETCH_RST_ADDR);
          first_req_seen = 1'b1;
        end
        delay = random_below(6);
        pend_addr.push_back(mem_req.addr);
        pend_opaq.push_back(mem_req.opaq);
        pend_due.push_back(cycle + delay);
      end
      // at most one response per cycle, echo addr and opaq
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        mem_resp_val  <= 1'b1;
        mem_resp.addr <= pend_addr[0];
        mem_resp.opaq <= pend_opaq[0];
        mem_resp.data <= mem_data(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_opaq.pop_front());
        void'(pend_due.pop_front());
      end else begin
        mem_resp_val <= 1'b0;
      end
      // decode transfer checked before any redirect at the same edge
      if (d_val && d_rdy) begin
        compare_value("d_msg.pc", d_msg.pc, exp_pc);
        compare_value("d_msg.inst", d_msg.inst, mem_data(exp_pc));
        exp_pc    = exp_pc + 32'd4;
        delivered = delivered + 1;
      end
      if (redirect_val) begin
        exp_pc = redirect.target & ~32'h3;
        if (!mem_req_val) begin
          stall_redirects = stall_redirects + 1;
        end
        if (prev_redirect) begin
          back_to_back = back_to_back + 1;
        end
      end
      prev_redirect = redirect_val;
      // new inputs for the next cycle
      mem_req_rdy <= (random_below(4) != 0);
      if (delivered < 100) begin
        d_rdy <= (random_below(4) != 0);
      end else if (delivered < 200) begin
        // heavy back-pressure, buffer and credits fill up
        d_rdy <= (random_below(10) < 3);
      end else begin
        d_rdy <= (random_below(2) != 0);
      end
      if (delivered < 200) begin
        redirect_val <= 1'b0;
      end else if (redirect_val) begin
        redirect_val <= (random_below(2) == 0);
      end else if (!mem_req_val) begin
        // stalled on credits
        redirect_val <= (random_below(4) == 0);
      end else begin
        redirect_val <= (random_below(12) == 0);
      end
      redirect.target <= lcg_next();
    end
  end

  // ------------------------------
  // run control
  // ------------------------------

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    lcg_state       = 32'd52;
    mem_req_rdy     = 1'b0;
    mem_resp_val    = 1'b0;
    mem_resp        = '0;
    d_rdy           = 1'b0;
    redirect_val    = 1'b0;
    redirect        = '0;
    cycle           = 0;
    delivered       = 0;
    exp_pc          = `FETCH_RST_ADDR;
    first_req_seen  = 1'b0;
    prev_redirect   = 1'b0;
    stall_redirects = 0;
    back_to_back    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait (delivered >= NUM_INST);
    if (stall_redirects > 0 && back_to_back > 0 && u_dut.u_props.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_failure("stall or back to back redirects never seen, or an assertion failed");
    end
  end

  // watchdog over the whole run, also stops on a failed assertion
  initial begin
    timeout_count = 0;
    while (timeout_count < TIMEOUT_CYCLES && u_dut.u_props.fail_count == 0) begin
      @(posedge clk);
      timeout_count = timeout_count + 1;
    end
    if (timeout_count >= TIMEOUT_CYCLES) begin
      stop_on_failure("timeout, not all instructions were delivered in time");
    end else begin
      stop_on_failure("a bound assertion on the fetch stage failed");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_pc_gen.sv
design/fetch_ctrl.sv
design/fetch_resp_buf.sv
design/fetch_unit.sv
test/fetch_unit_props.sv
test/fetch_unit_tb.sv
